/* Makefile */
# Verilator build and run for the segmented playback sequencer

VERILATOR ?= verilator
TOP       ?= tb_stm
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
rtl/stm_pkg.sv
rtl/stm_index_gen.sv
rtl/stm_swapchain.sv
rtl/stm_segment_mem.sv
rtl/stm_sample_out.sv
rtl/stm_top.sv
tb/stm_checker.sv
tb/tb_stm.sv

/* rtl/stm_index_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_index_gen #(
  parameter int MEM_DEPTH = 256
) (
  input  logic          CLK,
  input  logic          rst_n,
  input  stm_pkg::idx_t cycle,
  input  stm_pkg::idx_t div,
  output stm_pkg::idx_t idx
);
  import stm_pkg::*;

  localparam idx_t LAST_ADDR = idx_t'(MEM_DEPTH - 1);

  idx_t div_cnt;
  idx_t div_q;    // divider in use until the next step
  idx_t cycle_q;  // cycle length in use until the next step
  logic step;
  logic wrap;

  assign step = (div_cnt == div_q);

  // wrap at the end of the pass, or at the end of the memory
  assign wrap = (idx == idx_t'(cycle_q - 1'b1)) || (idx == LAST_ADDR);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      div_cnt <= '0;
      div_q   <= div;
      cycle_q <= cycle;
      idx     <= '0;
    end else if (step) begin
      div_cnt <= '0;
      div_q   <= div;   // new settings picked up here
      cycle_q <= cycle;
      if (wrap) begin
        idx <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/stm_pkg.sv */
`default_nettype none

package stm_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int IDX_W    = 16;
  localparam int REP_W    = 32;
  localparam int SAMPLE_W = 16;

  typedef logic [IDX_W-1:0]    idx_t;     // sample index within a segment
  typedef logic [REP_W-1:0]    rep_t;     // repeat count
  typedef logic [SAMPLE_W-1:0] sample_t;  // pattern sample

  // ============================================================
  // segment settings and indices
  // ============================================================
  typedef struct packed {
    idx_t cycle;  // samples per pass
    idx_t div;    // index step every div+1 clocks
    rep_t rep;    // extra passes for a finite segment
  } seg_cfg_t;

  typedef struct packed {
    idx_t idx1;
    idx_t idx0;
  } seg_idx_t;

  // all ones keeps the segment looping forever
  localparam rep_t REP_INFINITE = '1;

endpackage

`default_nettype wire

/* rtl/stm_sample_out.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_sample_out (
  input  logic             CLK,
  input  logic             rst_n,
  input  stm_pkg::sample_t rd0,
  input  stm_pkg::sample_t rd1,
  input  logic             segment,
  input  logic             stop,
  output stm_pkg::sample_t sample
);
  import stm_pkg::*;

  logic    seg_q;  // segment aligned with the read data
  sample_t sel;

  assign sel = seg_q ? rd1 : rd0;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      seg_q <= 1'b0;
    end else begin
      seg_q <= segment;
    end
  end

  // ============================================================
  // output register
  // ============================================================
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sample <= '0;
    end else if (!stop) begin
      sample <= sel;
    end
    // held at its last value while stopped
  end

endmodule

`default_nettype wire

/* rtl/stm_segment_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_segment_mem #(
  parameter int MEM_DEPTH = 256
) (
  input  logic              CLK,
  input  logic              wr_en,
  input  logic              wr_segment,
  input  stm_pkg::idx_t     wr_addr,
  input  stm_pkg::sample_t  wr_data,
  input  stm_pkg::seg_idx_t idx,
  output stm_pkg::sample_t  rd0,
  output stm_pkg::sample_t  rd1
);
  import stm_pkg::*;

  localparam int ADDR_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  sample_t mem0 [MEM_DEPTH];
  sample_t mem1 [MEM_DEPTH];

  logic [ADDR_W-1:0] waddr;
  logic [ADDR_W-1:0] raddr0;
  logic [ADDR_W-1:0] raddr1;

  assign waddr  = wr_addr[ADDR_W-1:0];
  assign raddr0 = idx.idx0[ADDR_W-1:0];
  assign raddr1 = idx.idx1[ADDR_W-1:0];

  // ============================================================
  // host write port
  // ============================================================
  always_ff @(posedge CLK) begin
    if (wr_en && !wr_segment) begin
      mem0[waddr] <= wr_data;
    end
    if (wr_en && wr_segment) begin
      mem1[waddr] <= wr_data;
    end
  end

  // ============================================================
  // playback reads
  // ============================================================
  always_ff @(posedge CLK) begin
    rd0 <= mem0[raddr0];  // one clock after the index
    rd1 <= mem1[raddr1];
  end

endmodule

`default_nettype wire

/* rtl/stm_swapchain.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_swapchain (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              update_settings,
  input  logic              req_segment,
  input  stm_pkg::rep_t     rep0,
  input  stm_pkg::rep_t     rep1,
  input  stm_pkg::seg_idx_t idx_in,
  output logic              segment,
  output logic              stop,
  output stm_pkg::seg_idx_t idx_out
);
  import stm_pkg::*;

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } state_t;

  state_t   state;
  logic     req_q;         // segment waiting to start
  rep_t     rep_q;         // its repeat count
  rep_t     loop_cnt;
  seg_idx_t idx_buf;       // indices one clock back
  rep_t     req_rep;
  idx_t     idx_req;
  idx_t     idx_act;
  idx_t     idx_act_prev;
  logic     act_wrap;

  // ============================================================
  // index views
  // ============================================================
  assign req_rep      = req_segment ? rep1 : rep0;
  assign idx_req      = req_q ? idx_in.idx1 : idx_in.idx0;
  assign idx_act      = segment ? idx_in.idx1 : idx_in.idx0;
  assign idx_act_prev = segment ? idx_buf.idx1 : idx_buf.idx0;

  // active index has just moved to zero
  assign act_wrap = (idx_act != idx_act_prev) && (idx_act == '0);

  assign idx_out = idx_buf;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      idx_buf <= '0;
    end else begin
      idx_buf <= idx_in;
    end
  end

  // ============================================================
  // segment selection and loop counting
  // ============================================================
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= INFINITE_LOOP;
      segment  <= 1'b0;
      stop     <= 1'b0;
      req_q    <= 1'b0;
      rep_q    <= '0;
      loop_cnt <= '0;
    end else if (update_settings) begin
      if (req_segment == segment) begin
        stop  <= 1'b0;            // restart in place
        state <= INFINITE_LOOP;
      end else if (req_rep == REP_INFINITE) begin
        stop    <= 1'b0;
        segment <= req_segment;
        state   <= INFINITE_LOOP;
      end else begin
        req_q    <= req_segment;
        rep_q    <= req_rep;
        loop_cnt <= '0;
        state    <= WAIT_START;
      end
    end else begin
      case (state)
        WAIT_START: begin
          if (idx_req == '0) begin  // target at the start of its pass
            stop     <= 1'b0;
            loop_cnt <= '0;
            segment  <= req_q;
            state    <= FINITE_LOOP;
          end
        end
        FINITE_LOOP: begin
          if (act_wrap) begin
            if (loop_cnt == rep_q) begin
              stop <= 1'b1;
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
        end
        INFINITE_LOOP: begin
          state <= INFINITE_LOOP;
        end
        default: begin
          state <= INFINITE_LOOP;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/stm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_top #(
  parameter int MEM_DEPTH = 256
) (
  input  logic              CLK,
  input  logic              rst_n,
  // segment settings
  input  stm_pkg::seg_cfg_t cfg0,
  input  stm_pkg::seg_cfg_t cfg1,
  input  logic              req_segment,
  input  logic              update_settings,
  // host writes
  input  logic              wr_en,
  input  logic              wr_segment,
  input  stm_pkg::idx_t     wr_addr,
  input  stm_pkg::sample_t  wr_data,
  // playback
  output logic              segment,
  output logic              stop,
  output stm_pkg::sample_t  sample,
  output stm_pkg::seg_idx_t idx
);
  import stm_pkg::*;

  seg_idx_t idx_raw;  // straight from the index generators
  sample_t  rd0;
  sample_t  rd1;

  // ============================================================
  // index generators
  // ============================================================
  stm_index_gen #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_index_gen0 (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cycle (cfg0.cycle),
    .div   (cfg0.div),
    .idx   (idx_raw.idx0)
  );

  stm_index_gen #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_index_gen1 (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cycle (cfg1.cycle),
    .div   (cfg1.div),
    .idx   (idx_raw.idx1)
  );

  // ============================================================
  // segment control and sample path
  // ============================================================
  stm_swapchain i_swapchain (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .update_settings (update_settings),
    .req_segment     (req_segment),
    .rep0            (cfg0.rep),
    .rep1            (cfg1.rep),
    .idx_in          (idx_raw),
    .segment         (segment),
    .stop            (stop),
    .idx_out         (idx)
  );

  stm_segment_mem #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_segment_mem (
    .CLK        (CLK),
    .wr_en      (wr_en),
    .wr_segment (wr_segment),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .idx        (idx),       // registered copy, sample trails it by two
    .rd0        (rd0),
    .rd1        (rd1)
  );

  stm_sample_out i_sample_out (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .rd0     (rd0),
    .rd1     (rd1),
    .segment (segment),
    .stop    (stop),
    .sample  (sample)
  );

endmodule

`default_nettype wire

/* tb/stm_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_checker (
  input logic          CLK,
  input logic          rst_n,
  input logic          update_settings,
  input logic          req_segment,
  input logic          segment,
  input logic          stop,
  input logic          req_q,
  input stm_pkg::rep_t loop_cnt,
  input stm_pkg::rep_t rep_q
);

  // ============================================================
  // swapchain properties
  // ============================================================

  // cleared by an update, or when a waiting segment starts
  a_stop_fall: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(stop) |-> $past(update_settings) || (segment != $past(segment)))
    else $error("stop fell without an update or a segment start");

  a_seg_change: assert property (@(posedge CLK) disable iff (!rst_n)
    (segment != $past(segment)) |->
      ($past(update_settings) ? (segment == $past(req_segment))
                              : (segment == $past(req_q))))  // waiting segment starts
    else $error("segment changed without a matching request");

  a_loop_cnt: assert property (@(posedge CLK) disable iff (!rst_n)
    loop_cnt <= rep_q)
    else $error("loop counter went past the repeat count");

endmodule

bind stm_swapchain stm_checker i_checker (
  .CLK             (CLK),
  .rst_n           (rst_n),
  .update_settings (update_settings),
  .req_segment     (req_segment),
  .segment         (segment),
  .stop            (stop),
  .req_q           (req_q),
  .loop_cnt        (loop_cnt),
  .rep_q           (rep_q)
);

`default_nettype wire

/* tb/stm_testdata.txt */
# cmd a b c d (hex operands): fill seg n base | cfg seg cycle div rep | upd req | run n
# wait_idx seg v | wait_seg v | wait_stop v | idx seg v ; mask 1 seg 2 stop 4 sample
fill      0 4 a000 0         0 0 0 0
fill      1 8 b000 0         0 0 0 0
cfg       0 4 0 ffffffff     0 0 0 0
cfg       1 8 1 ffffffff     3 0 0 0
wait_idx  0 3 0 0            0 0 0 0
run       1 0 0 0            0 0 0 0
idx       0 0 0 0            0 0 0 0
run       4 0 0 0            0 0 0 0
idx       0 0 0 0            0 0 0 0
wait_idx  1 7 0 0            0 0 0 0
run       2 0 0 0            0 0 0 0
idx       1 0 0 0            0 0 0 0
run       4 0 0 0            0 0 0 0
idx       1 2 0 0            0 0 0 0
wait_idx  0 2 0 0            0 0 0 0
run       2 0 0 0            7 0 0 a002
upd       1 0 0 0            3 1 0 0
wait_idx  1 5 0 0            0 0 0 0
run       2 0 0 0            7 1 0 b005
cfg       0 4 0 2            3 1 0 0
upd       0 0 0 0            3 1 0 0
wait_seg  0 0 0 0            3 0 0 0
idx       0 0 0 0            0 0 0 0
run       b 0 0 0            3 0 0 0
run       1 0 0 0            7 0 1 a002
run       5 0 0 0            7 0 1 a002
idx       0 1 0 0            0 0 0 0
upd       0 0 0 0            3 0 0 0
wait_stop 0 0 0 0            3 0 0 0
wait_idx  0 1 0 0            0 0 0 0
run       2 0 0 0            7 0 0 a001

/* tb/tb_stm.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stm;
  import stm_pkg::*;

  localparam int    CLK_PERIOD = 40;
  localparam int    DRIVE_DLY  = 2;
  localparam int    RST_CYCLES = 4;
  localparam int    MAX_WAIT   = 600;  // clocks allowed per data line
  localparam string DATA_FILE  = "tb/stm_testdata.txt";

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [2:0]  mask;  // 1 segment, 2 stop, 4 sample
    logic        seg;
    logic        stop;
    sample_t     sample;
  } vec_t;

  logic     CLK;
  logic     rst_n;
  seg_cfg_t cfg0;
  seg_cfg_t cfg1;
  logic     req_segment;
  logic     update_settings;
  logic     wr_en;
  logic     wr_segment;
  idx_t     wr_addr;
  sample_t  wr_data;
  logic     segment;
  logic     stop;
  sample_t  sample;
  seg_idx_t idx;

  string cmd_q[$];
  vec_t  vec_q[$];
  int    n_checks;
  int    n_errors;
  logic  loaded;

  stm_top #(
    .MEM_DEPTH (256)
  ) i_dut (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .cfg0            (cfg0),
    .cfg1            (cfg1),
    .req_segment     (req_segment),
    .update_settings (update_settings),
    .wr_en           (wr_en),
    .wr_segment      (wr_segment),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .segment         (segment),
    .stop            (stop),
    .sample          (sample),
    .idx             (idx)
  );

  // ============================================================
  // clock and watchdog
  // ============================================================
  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    wait (loaded);
    #((RST_CYCLES + cmd_q.size() * (MAX_WAIT + 2)) * CLK_PERIOD);
    $display("timeout: run exceeded the time allowed for %0d data lines", cmd_q.size());
    $display("TEST FAILED");
    $finish;
  end

  // ============================================================
  // helpers
  // ============================================================
  task automatic step();
    @(posedge CLK);
    #DRIVE_DLY;  // inputs change away from the edge
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("error %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      n_errors++;
    end
  endtask

  function automatic idx_t index_of(input logic seg);
    return seg ? idx.idx1 : idx.idx0;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          n;
    string       cmd;
    string       rest;
    logic [31:0] f [8];
    vec_t        v;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test data file %s", DATA_FILE);
      n_errors++;
      return;
    end
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd.substr(0, 0) == "#") begin
        n = $fgets(rest, fd);  // skip the comment text
      end else begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (n != 8) begin
          $display("data line for %s has %0d fields instead of 8", cmd, n);
          n_errors++;
        end
        v.a      = f[0];
        v.b      = f[1];
        v.c      = f[2];
        v.d      = f[3];
        v.mask   = f[4][2:0];
        v.seg    = f[5][0];
        v.stop   = f[6][0];
        v.sample = f[7][15:0];
        cmd_q.push_back(cmd);
        vec_q.push_back(v);
      end
    end
    $fclose(fd);
  endtask

  // ============================================================
  // commands
  // ============================================================
  task automatic fill_segment(input logic seg, input int n, input sample_t base);
    for (int i = 0; i < n; i++) begin
      wr_en      = 1'b1;
      wr_segment = seg;
      wr_addr    = idx_t'(i);
      wr_data    = base + sample_t'(i);
      step();
    end
    wr_en = 1'b0;
  endtask

  task automatic set_config(input logic seg, input idx_t cycle, input idx_t div,
                            input rep_t rep);
    seg_cfg_t c;
    c.cycle = cycle;
    c.div   = div;
    c.rep   = rep;
    if (seg) begin
      cfg1 = c;
    end else begin
      cfg0 = c;
    end
    step();
  endtask

  task automatic pulse_update(input logic req);
    req_segment     = req;
    update_settings = 1'b1;
    step();
    update_settings = 1'b0;
  endtask

  // waits for the index to arrive at v, not for one already sitting there
  task automatic wait_for_index(input logic seg, input idx_t v, output logic ok);
    int n;
    n = 0;
    while (index_of(seg) == v && n < MAX_WAIT) begin
      step();
      n++;
    end
    while (index_of(seg) != v && n < MAX_WAIT) begin
      step();
      n++;
    end
    ok = (index_of(seg) == v);
  endtask

  task automatic wait_for_level(input logic on_stop, input logic level, output logic ok);
    int n;
    n = 0;
    while (((on_stop ? stop : segment) != level) && n < MAX_WAIT) begin
      step();
      n++;
    end
    ok = ((on_stop ? stop : segment) == level);
  endtask

  task automatic run_command(input int t);
    string cmd;
    vec_t  v;
    logic  ok;
    cmd = cmd_q[t];
    v   = vec_q[t];
    ok  = 1'b1;
    if (cmd == "fill") begin
      fill_segment(v.a[0], int'(v.b), v.c[15:0]);
    end else if (cmd == "cfg") begin
      set_config(v.a[0], v.b[15:0], v.c[15:0], v.d);
    end else if (cmd == "upd") begin
      pulse_update(v.a[0]);
    end else if (cmd == "run") begin
      repeat (v.a) step();
    end else if (cmd == "wait_idx") begin
      wait_for_index(v.a[0], v.b[15:0], ok);
    end else if (cmd == "wait_seg") begin
      wait_for_level(1'b0, v.a[0], ok);
    end else if (cmd == "wait_stop") begin
      wait_for_level(1'b1, v.a[0], ok);
    end else if (cmd == "idx") begin
      check_value("index", 32'(index_of(v.a[0])), v.b);
    end else begin
      $display("unknown command %s on data line %0d", cmd, t + 1);
      n_errors++;
    end
    if (!ok) begin
      $display("timeout: %s on data line %0d did not finish in %0d clocks", cmd, t + 1,
               MAX_WAIT);
      n_errors++;
    end
    if (v.mask[0]) check_value("segment", 32'(segment), 32'(v.seg));
    if (v.mask[1]) check_value("stop", 32'(stop), 32'(v.stop));
    if (v.mask[2]) check_value("sample", 32'(sample), 32'(v.sample));
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    int err_before;
    rst_n           = 1'b0;
    cfg0            = '0;
    cfg1            = '0;
    req_segment     = 1'b0;
    update_settings = 1'b0;
    wr_en           = 1'b0;
    wr_segment      = 1'b0;
    wr_addr         = '0;
    wr_data         = '0;
    n_checks        = 0;
    n_errors        = 0;
    loaded          = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    #DRIVE_DLY;
    rst_n = 1'b1;
    for (int t = 0; t < cmd_q.size(); t++) begin
      err_before = n_errors;
      run_command(t);
      $display("test %0d %s: %s", t + 1, cmd_q[t], (n_errors == err_before) ? "ok" : "failed");
    end
    $display("%0d tests, %0d checks, %0d errors", cmd_q.size(), n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
